// ==== verilog/boardcfg_macros.svh ====
`ifndef BOARDCFG_MACROS_SVH
`define BOARDCFG_MACROS_SVH

// number of monitored clock inputs
`define BCFG_NCHAN 4

// gate window is 2**BCFG_GATE_BITS hw cycles
`define BCFG_GATE_BITS 10

// width of one channel count
`define BCFG_CNT_WIDTH 32

// free-running led blink counter width
`define BCFG_BLINK_BITS 8

// fixed revision word, bumped by hand per release
`define BCFG_REVISION 32'h0b1f_0102

`endif

// ==== verilog/boardcfg_reg_pkg.sv ====
`default_nettype none

package boardcfg_reg_pkg;

	// wishbone classic request, host side
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [3:0]  sel;
		logic [31:0] wdata;
	} wb_req_t;

	// wishbone classic response
	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		LED_PATTERN = 2'd0,
		LED_BLINK   = 2'd1,
		LED_STATUS  = 2'd2,
		LED_OFF     = 2'd3
	} led_src_e;

	// control word layout, lsb first from the bottom
	typedef struct packed {
		logic [19:0] rsvd;
		logic [7:0]  led_pattern;
		led_src_e    led_src;
		logic        soft_clear;
		logic        meas_en;
	} ctrl_fields_t;

	// bus side writes raw, datapath reads fields
	typedef union packed {
		logic [31:0]  raw;
		ctrl_fields_t fields;
	} ctrl_word_u;

	// what the led driver needs from the control word
	typedef struct packed {
		led_src_e   src;
		logic [7:0] pattern;
	} led_ctrl_t;

	// word addresses
	localparam logic [3:0] ADR_REVISION = 4'd0;
	localparam logic [3:0] ADR_CTRL     = 4'd1;
	localparam logic [3:0] ADR_STATUS   = 4'd2;
	localparam logic [3:0] ADR_SCRATCH  = 4'd3;
	localparam logic [3:0] ADR_FREQ0    = 4'd4;
	localparam logic [3:0] ADR_FREQ1    = 4'd5;
	localparam logic [3:0] ADR_FREQ2    = 4'd6;
	localparam logic [3:0] ADR_FREQ3    = 4'd7;

	// byte lane merge of a write into an old word
	function automatic logic [31:0] wb_merge(
		logic [31:0] old,
		logic [31:0] wdata,
		logic [3:0]  sel
	);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/boardcfg_meas_pkg.sv ====
`default_nettype none

`include "boardcfg_macros.svh"

package boardcfg_meas_pkg;

	// controller states, one round is clear, gate, latch
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_CLEAR = 2'd1,
		ST_GATE  = 2'd2,
		ST_LATCH = 2'd3
	} meas_state_e;

	// measurement status as seen by bank and leds
	typedef struct packed {
		logic        busy;
		logic        valid;
		logic [15:0] seq;
	} meas_status_t;

	// one extra bit so the full gate length fits
	typedef logic [`BCFG_GATE_BITS:0] gate_cnt_t;

	localparam gate_cnt_t GATE_LEN = gate_cnt_t'(1 << `BCFG_GATE_BITS);

	// edge count of one channel
	typedef logic [`BCFG_CNT_WIDTH-1:0] chan_count_t;

	// all channels side by side, channel 0 in the low word
	typedef chan_count_t [`BCFG_NCHAN-1:0] chan_counts_t;

endpackage

`default_nettype wire

// ==== verilog/freq_gate_timer.sv ====
`default_nettype none

module freq_gate_timer
	import boardcfg_meas_pkg::*;
(
	input  logic hw,
	input  logic arst_n,
	input  logic gate_start,
	output logic gate_done
);

	// zero means idle
	gate_cnt_t cnt;

	// loaded with full length, counts down to idle
	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (gate_start) begin
			cnt <= GATE_LEN;
		end else if (cnt != '0) begin
			cnt <= cnt - gate_cnt_t'(1);
		end
	end

	// last cycle of the window
	// gate_start in cycle c gives done in cycle c+GATE_LEN
	assign gate_done = (cnt == gate_cnt_t'(1));

	// controller must wait for the old window to drain
	a_no_restart: assert property (
		@(posedge hw) disable iff (!arst_n)
		gate_start |-> (cnt == '0)
	);

endmodule

`default_nettype wire

// ==== verilog/freq_meas_fsm.sv ====
`default_nettype none

module freq_meas_fsm
	import boardcfg_meas_pkg::*;
(
	input  logic         hw,
	input  logic         arst_n,
	input  logic         meas_en,
	input  logic         meas_clear,
	input  logic         gate_done,
	output logic         gate_start,
	output logic         cnt_clear,
	output logic         cnt_en,
	output logic         latch,
	output meas_status_t status
);

	meas_state_e state;
	meas_state_e state_nxt;
	// timer still running, set on start, dropped on done
	logic        gate_pend;
	logic        valid;
	logic [15:0] seq;

	always_comb begin
		state_nxt = state;
		case (state)
			// an aborted window must drain before a new one
			ST_IDLE:  if (meas_en && !gate_pend) state_nxt = ST_CLEAR;
			ST_CLEAR: state_nxt = ST_GATE;
			ST_GATE:  if (gate_done) state_nxt = ST_LATCH;
			ST_LATCH: state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
		// soft clear aborts from anywhere
		if (meas_clear)
			state_nxt = ST_IDLE;
	end

	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			gate_pend <= 1'b0;
			valid     <= 1'b0;
			seq       <= '0;
		end else begin
			state <= state_nxt;
			if (gate_start)
				gate_pend <= 1'b1;
			else if (gate_done)
				gate_pend <= 1'b0;
			// clear wins over a latch in the same cycle
			if (meas_clear) begin
				valid <= 1'b0;
				seq   <= '0;
			end else if (state == ST_LATCH) begin
				valid <= 1'b1;
				seq   <= seq + 16'd1;
			end
		end
	end

	// outputs decoded straight from state
	assign gate_start = (state == ST_CLEAR);
	assign cnt_clear  = (state == ST_CLEAR);
	assign cnt_en     = (state == ST_GATE);
	assign latch      = (state == ST_LATCH);

	assign status = '{busy: (state != ST_IDLE), valid: valid, seq: seq};

	// a latch always closes a full gate window opened by a clear
	a_latch_after_gate: assert property (
		@(posedge hw) disable iff (!arst_n)
		latch |-> $past(cnt_clear, int'(GATE_LEN) + 1)
	);

endmodule

`default_nettype wire

// ==== verilog/freq_edge_counter.sv ====
`default_nettype none

module freq_edge_counter
	import boardcfg_meas_pkg::*;
(
	input  logic        hw,
	input  logic        arst_n,
	input  logic        fin,
	input  logic        cnt_clear,
	input  logic        cnt_en,
	output chan_count_t count
);

	// two stage synchronizer plus history for the edge
	logic fin_s1;
	logic fin_s2;
	logic fin_hist;
	logic rise;

	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n) begin
			fin_s1   <= 1'b0;
			fin_s2   <= 1'b0;
			fin_hist <= 1'b0;
		end else begin
			fin_s1   <= fin;
			fin_s2   <= fin_s1;
			fin_hist <= fin_s2;
		end
	end

	// rising edge seen three hw cycles after the pin
	assign rise = fin_s2 && !fin_hist;

	// clear first, then count while the gate is open
	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (cnt_clear) begin
			count <= '0;
		end else if (cnt_en && rise && (count != '1)) begin
			// stops at all ones instead of wrapping
			count <= count + chan_count_t'(1);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/boardcfg_regs.sv ====
`default_nettype none

`include "boardcfg_macros.svh"

module boardcfg_regs
	import boardcfg_reg_pkg::*;
	import boardcfg_meas_pkg::*;
(
	input  logic         hw,
	input  logic         arst_n,
	input  wb_req_t      wb_req,
	output wb_rsp_t      wb_rsp,
	input  meas_status_t status,
	input  chan_counts_t counts,
	input  logic         latch,
	output logic         meas_en,
	output logic         meas_clear,
	output led_ctrl_t    led_ctrl
);

	logic         req;
	logic         ack;
	logic         wr;
	logic [31:0]  rdata;
	logic [31:0]  rd_word;
	logic [31:0]  status_word;
	logic [31:0]  scratch;
	ctrl_word_u   ctrl;
	// merged write, and what actually gets stored
	ctrl_word_u   ctrl_wr;
	ctrl_word_u   ctrl_nxt;
	chan_counts_t freq;

	assign req = wb_req.cyc && wb_req.stb;
	// one access per ack, the cycle after an ack is never taken
	assign wr = req && !ack && wb_req.we;

	always_comb begin
		ctrl_wr.raw = wb_merge(ctrl.raw, wb_req.wdata, wb_req.sel);
		ctrl_nxt = ctrl_wr;
		// soft_clear is a strobe only
		ctrl_nxt.fields.soft_clear = 1'b0;
		ctrl_nxt.fields.rsvd = '0;
	end

	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n) begin
			ack        <= 1'b0;
			meas_clear <= 1'b0;
			ctrl       <= '0;
			scratch    <= '0;
		end else begin
			ack        <= req && !ack;
			meas_clear <= 1'b0;
			if (wr) begin
				case (wb_req.adr)
					ADR_CTRL: begin
						ctrl       <= ctrl_nxt;
						meas_clear <= ctrl_wr.fields.soft_clear;
					end
					ADR_SCRATCH: scratch <= wb_merge(scratch, wb_req.wdata, wb_req.sel);
					// read-only and unmapped words ignore writes
					default: ;
				endcase
			end
		end
	end

	// result snapshot per round, clear has priority
	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n)
			freq <= '0;
		else if (meas_clear)
			freq <= '0;
		else if (latch)
			freq <= counts;
	end

	// busy bit 0, valid bit 1, seq on top
	assign status_word = {status.seq, 14'd0, status.valid, status.busy};

	always_comb begin
		rd_word = '0;
		case (wb_req.adr)
			ADR_REVISION: rd_word = `BCFG_REVISION;
			ADR_CTRL:     rd_word = ctrl.raw;
			ADR_STATUS:   rd_word = status_word;
			ADR_SCRATCH:  rd_word = scratch;
			ADR_FREQ0:    rd_word = freq[0];
			ADR_FREQ1:    rd_word = freq[1];
			ADR_FREQ2:    rd_word = freq[2];
			ADR_FREQ3:    rd_word = freq[3];
			default:      rd_word = '0;
		endcase
	end

	// read data only looked at while ack is high
	always_ff @(posedge hw) begin
		if (req && !ack)
			rdata <= rd_word;
	end

	assign wb_rsp = '{ack: ack, rdata: rdata};

	assign meas_en  = ctrl.fields.meas_en;
	assign led_ctrl = '{src: ctrl.fields.led_src, pattern: ctrl.fields.led_pattern};

endmodule

`default_nettype wire

// ==== verilog/led_driver.sv ====
`default_nettype none

`include "boardcfg_macros.svh"

module led_driver
	import boardcfg_reg_pkg::*;
	import boardcfg_meas_pkg::*;
(
	input  logic         hw,
	input  logic         arst_n,
	input  led_ctrl_t    led_ctrl,
	input  meas_status_t status,
	output logic [7:0]   led
);

	logic [`BCFG_BLINK_BITS-1:0] blink_cnt;
	logic                        blink;

	// free running, never stopped
	always_ff @(posedge hw or negedge arst_n) begin
		if (!arst_n)
			blink_cnt <= '0;
		else
			blink_cnt <= blink_cnt + 1'b1;
	end

	assign blink = blink_cnt[`BCFG_BLINK_BITS-1];

	always_comb begin
		case (led_ctrl.src)
			LED_PATTERN: led = led_ctrl.pattern;
			// even leds follow blink, odd leds the inverse
			LED_BLINK:   led = {4{~blink, blink}};
			// valid on led 0, busy on led 1, low seq above
			LED_STATUS:  led = {status.seq[5:0], status.busy, status.valid};
			default:     led = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/boardcfg.sv ====
`default_nettype none

`include "boardcfg_macros.svh"

module boardcfg (
	input  logic                          hw,
	input  logic                          arst_n,
	input  boardcfg_reg_pkg::wb_req_t     wb_req,
	output boardcfg_reg_pkg::wb_rsp_t     wb_rsp,
	input  logic [`BCFG_NCHAN-1:0]        fin,
	output logic [7:0]                    led
);

	// bank to controller and leds
	logic                            meas_en;
	logic                            meas_clear;
	boardcfg_reg_pkg::led_ctrl_t     led_ctrl;
	// controller to timer, counters and bank
	logic                            gate_start;
	logic                            gate_done;
	logic                            cnt_clear;
	logic                            cnt_en;
	logic                            latch;
	boardcfg_meas_pkg::meas_status_t status;
	boardcfg_meas_pkg::chan_counts_t counts;

	boardcfg_regs u_regs (
		.hw         (hw),
		.arst_n     (arst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.status     (status),
		.counts     (counts),
		.latch      (latch),
		.meas_en    (meas_en),
		.meas_clear (meas_clear),
		.led_ctrl   (led_ctrl)
	);

	freq_meas_fsm u_fsm (
		.hw         (hw),
		.arst_n     (arst_n),
		.meas_en    (meas_en),
		.meas_clear (meas_clear),
		.gate_done  (gate_done),
		.gate_start (gate_start),
		.cnt_clear  (cnt_clear),
		.cnt_en     (cnt_en),
		.latch      (latch),
		.status     (status)
	);

	freq_gate_timer u_timer (
		.hw         (hw),
		.arst_n     (arst_n),
		.gate_start (gate_start),
		.gate_done  (gate_done)
	);

	// one counter per monitored input, all share the gate
	for (genvar i = 0; i < `BCFG_NCHAN; i++) begin : gen_chan
		freq_edge_counter u_cnt (
			.hw        (hw),
			.arst_n    (arst_n),
			.fin       (fin[i]),
			.cnt_clear (cnt_clear),
			.cnt_en    (cnt_en),
			.count     (counts[i])
		);
	end

	led_driver u_led (
		.hw       (hw),
		.arst_n   (arst_n),
		.led_ctrl (led_ctrl),
		.status   (status),
		.led      (led)
	);

endmodule

`default_nettype wire

// ==== dv/boardcfg_tb.sv ====
`default_nettype none

`include "boardcfg_macros.svh"

module boardcfg_tb
	import boardcfg_reg_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// cycles to wait for one ack
	localparam int ACK_LIMIT  = 16;
	// status reads before giving up, a round is about 1030 cycles
	localparam int POLL_LIMIT = 1000;
	localparam int GATE_LEN   = 1 << `BCFG_GATE_BITS;

	logic                   hw;
	logic                   arst_n;
	wb_req_t                wb_req;
	wb_rsp_t                wb_rsp;
	logic [`BCFG_NCHAN-1:0] fin;
	logic [7:0]             led;

	integer      seed;
	int          half_cnt [`BCFG_NCHAN];
	// high while the leds are in blink mode
	logic        blink_on;
	logic [31:0] scratch_model;

	boardcfg u_boardcfg (
		.hw     (hw),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.fin    (fin),
		.led    (led)
	);

	always #20 hw = ~hw;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// fin half periods in hw cycles
	function automatic int half_period(input int ch);
		case (ch)
			0:       return 2;
			1:       return 3;
			2:       return 5;
			default: return 8;
		endcase
	endfunction

	// monitored inputs, changed off the clock edge
	always @(posedge hw) begin
		#2;
		for (int i = 0; i < `BCFG_NCHAN; i++) begin
			if (half_cnt[i] == half_period(i) - 1) begin
				half_cnt[i] = 0;
				fin[i] = ~fin[i];
			end else begin
				half_cnt[i] = half_cnt[i] + 1;
			end
		end
	end

	// byte enables applied to an old word
	function automatic logic [31:0] apply_sel(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	// meas_en bit 0, soft_clear bit 1, src 3:2, pattern 11:4
	function automatic logic [31:0] ctrl_word(input logic en, input logic clr,
		input led_src_e src, input logic [7:0] pattern);
		return {20'd0, pattern, src, clr, en};
	endfunction

	a_ack_single: assert property (@(posedge hw) disable iff (!arst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else stop_run($sformatf("FAILED at %0t: ack held longer than one cycle", $time));

	a_ack_after_req: assert property (@(posedge hw) disable iff (!arst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else stop_run($sformatf("FAILED at %0t: ack without a request", $time));

	// even and odd leds are opposite in blink mode
	a_blink_compl: assert property (@(posedge hw) disable iff (!arst_n)
		blink_on |-> ({led[6], led[4], led[2], led[0]} == ~{led[7], led[5], led[3], led[1]}))
		else stop_run($sformatf("FAILED at %0t: blink leds not complementary", $time));

	// returns just after the ack edge, cycles counts edges waited
	task automatic await_ack(output int cycles);
		logic got;
		got = 1'b0;
		cycles = 0;
		while (!got && cycles < ACK_LIMIT) begin
			@(posedge hw);
			#1;
			cycles++;
			got = wb_rsp.ack;
		end
		if (!got)
			stop_run("timed out waiting for a Wishbone ack");
	endtask

	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [3:0] sel,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(posedge hw);
		#2;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, wdata: wdata};
		await_ack(n);
		rdata = wb_rsp.rdata;
		#1;
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [3:0] sel,
		input logic [31:0] data);
		logic [31:0] ignored;
		bus_cycle(1'b1, adr, sel, data, ignored);
	endtask

	task automatic bus_read(input logic [3:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 4'hf, 32'h0, data);
	endtask

	task automatic expect_read(input logic [3:0] adr, input logic [31:0] exp, input string what);
		logic [31:0] got;
		bus_read(adr, got);
		assert (got === exp)
			else stop_run($sformatf("FAILED at %0t: %s read %h, expected %h",
				$time, what, got, exp));
	endtask

	// STATUS until the masked bits match
	task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
		input string what, output logic [31:0] word);
		word = '0;
		for (int n = 0; n < POLL_LIMIT; n++) begin
			bus_read(ADR_STATUS, word);
			if ((word & mask) == want)
				break;
		end
		if ((word & mask) != want)
			stop_run($sformatf("timed out waiting for %s in STATUS", what));
	endtask

	initial begin
		logic [31:0] word;
		logic [31:0] data;
		logic [3:0]  sel;
		logic [15:0] seq0;
		logic        led0;
		int          period;
		int          lo;
		int          hi;
		int          n;
		hw            = 1'b0;
		arst_n        = 1'b0;
		wb_req        = '0;
		fin           = '0;
		blink_on      = 1'b0;
		scratch_model = '0;
		seed          = 32'h8a32_9c2f;
		for (int i = 0; i < `BCFG_NCHAN; i++)
			half_cnt[i] = 0;
		repeat (16) @(posedge hw);
		#2;
		arst_n = 1'b1;
		@(posedge hw);
		#1;

		// reset values
		assert (wb_rsp.ack === 1'b0 && led === 8'h00)
			else stop_run($sformatf("FAILED at %0t: ack or led set after reset", $time));
		expect_read(ADR_REVISION, `BCFG_REVISION, "REVISION");
		expect_read(ADR_CTRL, 32'h0, "CTRL after reset");
		expect_read(ADR_STATUS, 32'h0, "STATUS after reset");
		for (int i = 0; i < `BCFG_NCHAN; i++)
			expect_read(ADR_FREQ0 + 4'(i), 32'h0, "FREQ after reset");

		// scratch with mixed byte enables
		for (int k = 0; k < 8; k++) begin
			data = $random(seed);
			sel  = 4'($random(seed));
			bus_write(ADR_SCRATCH, sel, data);
			scratch_model = apply_sel(scratch_model, data, sel);
			expect_read(ADR_SCRATCH, scratch_model, "SCRATCH");
		end
		// unmapped words still answer, read zero
		bus_write(4'd8, 4'hf, 32'hdead_beef);
		expect_read(4'd8, 32'h0, "unmapped 8");
		expect_read(4'd15, 32'h0, "unmapped 15");
		// results are read only
		for (int i = 0; i < `BCFG_NCHAN; i++) begin
			bus_write(ADR_FREQ0 + 4'(i), 4'hf, 32'hffff_ffff);
			expect_read(ADR_FREQ0 + 4'(i), 32'h0, "FREQ after write");
		end

		// start measuring, wait for the first round
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b1, 1'b0, LED_PATTERN, 8'h00));
		poll_status(32'h2, 32'h2, "the first valid result", word);
		seq0 = word[31:16];
		for (int i = 0; i < `BCFG_NCHAN; i++) begin
			bus_read(ADR_FREQ0 + 4'(i), data);
			period = 2 * half_period(i);
			lo = GATE_LEN / period - 1;
			hi = (GATE_LEN + period - 1) / period + 1;
			assert (int'(data) >= lo && int'(data) <= hi)
				else stop_run($sformatf("FAILED at %0t: FREQ%0d is %0d, expected %0d to %0d",
					$time, i, data, lo, hi));
		end
		// next round bumps seq
		word = '0;
		for (n = 0; n < POLL_LIMIT; n++) begin
			bus_read(ADR_STATUS, word);
			if (word[31:16] > seq0)
				break;
		end
		if (word[31:16] <= seq0)
			stop_run("timed out waiting for seq to advance past the first round");

		// status leds, after the controller has stopped
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b0, 1'b0, LED_STATUS, 8'h00));
		poll_status(32'h1, 32'h0, "the measurement to go idle", word);
		assert (word[1] === 1'b1 && led === {word[21:16], word[0], word[1]})
			else stop_run($sformatf("FAILED at %0t: status leds %h for STATUS %h",
				$time, led, word));
		data = 32'($random(seed));
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b0, 1'b0, LED_PATTERN, data[7:0]));
		assert (led === data[7:0])
			else stop_run($sformatf("FAILED at %0t: pattern leds %h, expected %h",
				$time, led, data[7:0]));
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b0, 1'b0, LED_OFF, 8'hff));
		assert (led === 8'h00)
			else stop_run($sformatf("FAILED at %0t: leds %h in off mode", $time, led));
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b0, 1'b0, LED_BLINK, 8'hff));
		blink_on = 1'b1;
		led0 = led[0];
		for (n = 0; n < (1 << `BCFG_BLINK_BITS); n++) begin
			@(posedge hw);
			#1;
			if (led[0] !== led0)
				break;
		end
		if (led[0] === led0)
			stop_run("blink leds did not toggle within the blink period");
		blink_on = 1'b0;

		// soft clear with measurement off
		bus_write(ADR_CTRL, 4'hf, ctrl_word(1'b0, 1'b1, LED_PATTERN, 8'h00));
		expect_read(ADR_STATUS, 32'h0, "STATUS after soft clear");
		for (int i = 0; i < `BCFG_NCHAN; i++)
			expect_read(ADR_FREQ0 + 4'(i), 32'h0, "FREQ after soft clear");
		bus_read(ADR_CTRL, word);
		assert (word[1] === 1'b0)
			else stop_run($sformatf("FAILED at %0t: soft_clear stored in CTRL %h", $time, word));

		// stb held across two reads, one ack each
		@(posedge hw);
		#2;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: ADR_REVISION, sel: 4'hf, wdata: 32'h0};
		await_ack(n);
		assert (wb_rsp.rdata === `BCFG_REVISION)
			else stop_run($sformatf("FAILED at %0t: held read of REVISION gave %h",
				$time, wb_rsp.rdata));
		#1;
		wb_req.adr = ADR_SCRATCH;
		await_ack(n);
		assert (n == 2 && wb_rsp.rdata === scratch_model)
			else stop_run($sformatf("FAILED at %0t: second held ack after %0d cycles, data %h",
				$time, n, wb_rsp.rdata));
		#1;
		wb_req = '0;

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/boardcfg_reg_pkg.sv
verilog/boardcfg_meas_pkg.sv
verilog/freq_gate_timer.sv
verilog/freq_meas_fsm.sv
verilog/freq_edge_counter.sv
verilog/boardcfg_regs.sv
verilog/led_driver.sv
verilog/boardcfg.sv
dv/boardcfg_tb.sv

// ==== Makefile ====
TOP = boardcfg_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f project.f --top-module $(TOP)

# pass only when the simulation prints the pass line
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		-f project.f --top-module boardcfg

clean:
	rm -rf obj_dir
